// ==== Makefile ====
SRCS := $(shell grep -v '^+' addrgen.f) addrgen_consts.svh

.PHONY: all run clean

all: obj_dir/Vtb_addrgen

obj_dir/Vtb_addrgen: addrgen.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_addrgen -f addrgen.f -Mdir obj_dir

run: obj_dir/Vtb_addrgen
	@out="$$(./obj_dir/Vtb_addrgen 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// ==== addrgen.f ====
+incdir+.
vmem_pkg.sv
axi_ax_pkg.sv
vmem_req_check.sv
ax_burst_split.sv
ax_cmd_queue.sv
addrgen.sv
tb_addrgen.sv

// ==== addrgen.sv ====
////////////////////////////////////////////////////////////////////////////
// Vector load/store address generator with AR/AW and load/store commands
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addrgen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer
  input  vmem_pkg::vmem_req_t    req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output logic                   ack_o,
  output vmem_pkg::addrgen_ack_t ack_info_o,
  // AXI address channels
  output axi_ax_pkg::ax_beat_t   ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output axi_ax_pkg::ax_beat_t   aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  // Load/store units
  output axi_ax_pkg::lsu_cmd_t   lsu_cmd_o,
  output logic                   lsu_cmd_valid_o,
  input  logic                   lsu_cmd_ready_i
);
  import axi_ax_pkg::*;

  split_req_t split_req;
  logic       split_valid;
  logic       split_ready;
  logic       split_done;
  logic       push;
  lsu_cmd_t   push_cmd;
  logic       q_full;
  logic       q_empty;
  logic       q_head_is_load;

  vmem_req_check req_check_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .split_req_o   (split_req),
    .split_valid_o (split_valid),
    .split_ready_i (split_ready),
    .split_done_i  (split_done),
    .ack_o         (ack_o),
    .ack_info_o    (ack_info_o)
  );

  ax_burst_split burst_split_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .split_req_i      (split_req),
    .split_valid_i    (split_valid),
    .split_ready_o    (split_ready),
    .split_done_o     (split_done),
    .ar_o             (ar_o),
    .ar_valid_o       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .aw_o             (aw_o),
    .aw_valid_o       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (q_head_is_load),
    .push_o           (push),
    .push_cmd_o       (push_cmd)
  );

  ax_cmd_queue cmd_queue_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .push_cmd_i      (push_cmd),
    .full_o          (q_full),
    .empty_o         (q_empty),
    .head_is_load_o  (q_head_is_load),
    .lsu_cmd_o       (lsu_cmd_o),
    .lsu_cmd_valid_o (lsu_cmd_valid_o),
    .lsu_cmd_ready_i (lsu_cmd_ready_i)
  );

endmodule

`default_nettype wire

// ==== addrgen_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Constants of the vector address generator for bus, page, burst and queue
////////////////////////////////////////////////////////////////////////////

`ifndef ADDRGEN_CONSTS_SVH
`define ADDRGEN_CONSTS_SVH

// Memory bus
`define ADDR_WIDTH 32
`define AXI_DATA_BYTES 8
`define AXI_SIZE_LOG 3

// Vector length and element index width
`define VLEN_WIDTH 16

// AXI bursts stay inside one 4 KiB page and never exceed 256 beats
`define PAGE_BITS 12
`define MAX_BURST_BEATS 256

// Commands in flight toward the load/store units
`define ADDRGEN_QUEUE_DEPTH 4

`endif

// ==== ax_burst_split.sv ====
////////////////////////////////////////////////////////////////////////////
// Burst engine that splits one request into AXI address transactions
// and pushes a matching command for each into the load/store queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module ax_burst_split (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  axi_ax_pkg::split_req_t split_req_i,
  input  logic                   split_valid_i,
  output logic                   split_ready_o,
  output logic                   split_done_o,
  output axi_ax_pkg::ax_beat_t   ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output axi_ax_pkg::ax_beat_t   aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  input  logic                   q_full_i,
  input  logic                   q_empty_i,
  input  logic                   q_head_is_load_i,
  output logic                   push_o,
  output axi_ax_pkg::lsu_cmd_t   push_cmd_o
);
  import vmem_pkg::*;
  import axi_ax_pkg::*;

  localparam addr_t BeatMask   = addr_t'(`AXI_DATA_BYTES - 1);
  localparam addr_t BurstBytes = addr_t'(`MAX_BURST_BEATS * `AXI_DATA_BYTES);
  localparam addr_t PageMask   = addr_t'((1 << `PAGE_BITS) - 1);

  typedef enum logic [1:0] {IDLE, PLAN, REQUEST} state_e;

  state_e     state_q, state_d;
  split_req_t req_q;
  addr_t      addr_q, addr_d;
  addr_t      end_q, end_d;
  vlen_t      remain_q, remain_d;
  logic [2:0] size_q;

  vlen_t      consumed;
  logic [7:0] beat_len;
  logic       q_ok;
  logic       fire;

  // Last byte covered by the transaction that starts at addr
  function automatic addr_t txn_end(addr_t addr, vlen_t count, vew_e vew, logic is_burst);
    addr_t last_byte;
    addr_t beat_end;
    addr_t page_end;
    last_byte = addr + (addr_t'(count) << vew) - addr_t'(1);
    beat_end  = (addr & ~BeatMask) + BurstBytes - addr_t'(1);
    page_end  = addr | PageMask;
    txn_end   = last_byte;
    if (beat_end < txn_end) txn_end = beat_end;
    if (page_end < txn_end) txn_end = page_end;
    // A strided element is a single beat of its own size
    if (!is_burst) txn_end = addr + (addr_t'(1) << vew) - addr_t'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Channel handshake

  // The queue holds one direction at a time, so a load never waits behind a store
  assign q_ok       = !q_full_i && (q_empty_i || q_head_is_load_i == req_q.is_load);
  assign ar_valid_o = state_q == REQUEST && req_q.is_load && q_ok;
  assign aw_valid_o = state_q == REQUEST && !req_q.is_load && q_ok;
  assign fire       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Beats counted from the bus-aligned start up to the end address
  assign beat_len = req_q.is_burst ?
                    8'((end_q >> `AXI_SIZE_LOG) - (addr_q >> `AXI_SIZE_LOG)) : 8'd0;

  assign ar_o = '{addr: addr_q, len: beat_len, size: size_q, burst: BURST_INCR};
  assign aw_o = '{addr: addr_q, len: beat_len, size: size_q, burst: BURST_INCR};

  assign push_o     = fire;
  assign push_cmd_o = '{addr: addr_q, len: beat_len, size: size_q, is_load: req_q.is_load};

  assign split_ready_o = state_q == IDLE;

  ////////////////////////////////////////////////////////////////////////////
  // Transaction sequencing

  always_comb begin
    state_d      = state_q;
    addr_d       = addr_q;
    remain_d     = remain_q;
    end_d        = end_q;
    split_done_o = 1'b0;
    consumed     = vlen_t'((end_q - addr_q + addr_t'(1)) >> req_q.vew);
    case (state_q)
      IDLE: begin
        if (split_valid_i) begin
          addr_d   = split_req_i.addr;
          remain_d = split_req_i.len;
          state_d  = PLAN;
        end
      end
      PLAN: begin
        end_d   = txn_end(addr_q, remain_q, req_q.vew, req_q.is_burst);
        state_d = REQUEST;
      end
      REQUEST: begin
        if (fire) begin
          addr_d   = req_q.is_burst ? end_q + addr_t'(1) : addr_q + req_q.stride;
          remain_d = (remain_q > consumed) ? remain_q - consumed : '0;
          // Next transaction is ready right after this handshake
          end_d    = txn_end(addr_d, remain_d, req_q.vew, req_q.is_burst);
          if (remain_d == '0) begin
            split_done_o = 1'b1;
            state_d      = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q   <= addr_d;
    remain_q <= remain_d;
    end_q    <= end_d;
    if (split_valid_i && split_ready_o) begin
      req_q  <= split_req_i;
      size_q <= split_req_i.is_burst ? 3'(`AXI_SIZE_LOG) : 3'(split_req_i.vew);
    end
  end

endmodule

`default_nettype wire

// ==== ax_cmd_queue.sv ====
////////////////////////////////////////////////////////////////////////////
// FIFO of commands toward the load/store units
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module ax_cmd_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  axi_ax_pkg::lsu_cmd_t push_cmd_i,
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 head_is_load_o,
  output axi_ax_pkg::lsu_cmd_t lsu_cmd_o,
  output logic                 lsu_cmd_valid_o,
  input  logic                 lsu_cmd_ready_i
);
  import axi_ax_pkg::*;

  localparam int unsigned Depth = `ADDRGEN_QUEUE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  lsu_cmd_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop = lsu_cmd_valid_o && lsu_cmd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      // Simultaneous push and pop keep the count
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_cmd_i;
  end

  assign full_o          = count_q == (PtrW + 1)'(Depth);
  assign empty_o         = count_q == '0;
  assign lsu_cmd_o       = mem_q[rd_ptr_q];
  assign head_is_load_o  = lsu_cmd_o.is_load;
  assign lsu_cmd_valid_o = !empty_o;

endmodule

`default_nettype wire

// ==== axi_ax_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types of AXI address beats, load/store commands and split requests
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "addrgen_consts.svh"

package axi_ax_pkg;

  localparam logic [1:0] BURST_INCR = 2'b01;

  typedef struct packed {
    vmem_pkg::addr_t addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
  } ax_beat_t;

  // One entry per AXI transaction, consumed by the load or store unit
  typedef struct packed {
    vmem_pkg::addr_t addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic            is_load;
  } lsu_cmd_t;

  // Checked instruction handed from the front end to the burst engine
  typedef struct packed {
    vmem_pkg::addr_t addr;
    vmem_pkg::vlen_t len;
    vmem_pkg::addr_t stride;
    vmem_pkg::vew_e  vew;
    logic            is_load;
    logic            is_burst;
  } split_req_t;

endpackage

`default_nettype wire

// ==== tb_addrgen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the vector address generator, driven from an instruction table
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module tb_addrgen;
  import vmem_pkg::*;
  import axi_ax_pkg::*;

  localparam int unsigned NumRows   = 14;
  localparam int unsigned MaxCycles = 200 * NumRows + 100;

  typedef struct packed {
    vmem_op_e op;
    addr_t    base;
    addr_t    stride;
    vlen_t    vl;
    vlen_t    vstart;
    vew_e     vew;
    logic     slow;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  vmem_req_t req_i;
  logic req_valid_i, req_ready_o, ack_o;
  addrgen_ack_t ack_info_o;
  ax_beat_t ar_o, aw_o;
  logic ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  lsu_cmd_t lsu_cmd_o;
  logic lsu_cmd_valid_o, lsu_cmd_ready_i;

  row_t         rows [NumRows];
  int unsigned  row_cnt = 0;
  lsu_cmd_t     exp_ax [$];
  lsu_cmd_t     exp_lsu [$];
  addrgen_ack_t exp_ack;
  logic         exp_bad;
  logic         lsu_slow = 1'b0;
  int unsigned  ack_cnt = 0;
  int unsigned  load_pushes = 0;
  int unsigned  load_pops = 0;
  int unsigned  cycles = 0;

  addrgen dut_i (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic value_error(input string msg);
    abort_run($sformatf("** Error [%0t] %s", $time, msg));
  endtask

  task automatic add_row(input vmem_op_e op, input addr_t base, input addr_t stride,
                         input vlen_t vl, input vlen_t vstart, input vew_e vew,
                         input logic slow);
    rows[row_cnt] = '{op: op, base: base, stride: stride, vl: vl, vstart: vstart,
                      vew: vew, slow: slow};
    row_cnt++;
  endtask

  // Expected transactions and acknowledge of one instruction
  task automatic plan_row(input row_t r);
    addr_t       addr, last, beat_end, page_end, stop, ebytes;
    int unsigned remain, used, i;
    logic        is_load, is_burst;
    is_load  = r.op == VLE || r.op == VLSE;
    is_burst = r.op == VLE || r.op == VSE;
    remain   = 32'(r.vl - r.vstart);
    ebytes   = addr_t'(1) << r.vew;
    addr     = is_burst ? r.base + addr_t'(r.vstart) * ebytes
                        : r.base + addr_t'(r.vstart) * r.stride;
    exp_bad  = (addr % ebytes != 0) || (r.stride % ebytes != 0 && remain > 1);
    exp_ack.err       = !exp_bad ? ERR_NONE :
                        is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
    exp_ack.err_vl    = r.vstart;
    exp_ack.err_vaddr = addr;
    if (!exp_bad && is_burst) begin
      while (remain > 0) begin
        last     = addr + addr_t'(remain) * ebytes - 1;
        beat_end = addr - addr % `AXI_DATA_BYTES + `MAX_BURST_BEATS * `AXI_DATA_BYTES - 1;
        page_end = addr - addr % (1 << `PAGE_BITS) + (1 << `PAGE_BITS) - 1;
        stop     = last;
        if (beat_end < stop) stop = beat_end;
        if (page_end < stop) stop = page_end;
        exp_ax.push_back('{addr: addr, len: 8'(stop / `AXI_DATA_BYTES - addr / `AXI_DATA_BYTES),
                           size: 3'(`AXI_SIZE_LOG), is_load: is_load});
        used   = 32'((stop - addr + 1) / ebytes);
        remain = (remain > used) ? remain - used : 0;
        addr   = stop + 1;
      end
    end else if (!exp_bad) begin
      for (i = 0; i < remain; i++) begin
        exp_ax.push_back('{addr: addr, len: 8'd0, size: 3'(r.vew), is_load: is_load});
        addr = addr + r.stride;
      end
    end
  endtask

  task automatic send_req(input row_t r);
    @(posedge clk_i);
    #1;
    req_i = '{op: r.op, base: r.base, stride: r.stride, vl: r.vl, vstart: r.vstart,
              vew: r.vew};
    req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Ready signals, each high about 70 % of the time unless the LSU is slow
  always @(posedge clk_i) begin
    #1;
    ar_ready_i      = ($urandom % 100) < 70;
    aw_ready_i      = ($urandom % 100) < 70;
    lsu_cmd_ready_i = ($urandom % 100) < (lsu_slow ? 20 : 70);
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) abort_run($sformatf("Run timed out after %0d cycles", cycles));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-cycle where all signals are settled

  always @(negedge clk_i) begin
    lsu_cmd_t cmd;
    if (rst_ni) begin
      if (lsu_cmd_valid_o && lsu_cmd_ready_i) begin
        assert (exp_lsu.size() != 0) else abort_run("LSU command popped that was never issued");
        cmd = exp_lsu.pop_front();
        assert (lsu_cmd_o == cmd) else value_error($sformatf(
          "LSU cmd %h len %0d size %0d load %0b, expected %h len %0d size %0d load %0b",
          lsu_cmd_o.addr, lsu_cmd_o.len, lsu_cmd_o.size, lsu_cmd_o.is_load,
          cmd.addr, cmd.len, cmd.size, cmd.is_load));
        if (cmd.is_load) load_pops++;
      end
      if (ar_valid_o && ar_ready_i) begin
        assert (exp_ax.size() != 0) else abort_run("AR handshake that no instruction asked for");
        cmd = exp_ax.pop_front();
        // Burst type is always INCR
        assert (cmd.is_load && ar_o.addr == cmd.addr && ar_o.len == cmd.len &&
                ar_o.size == cmd.size && ar_o.burst == 2'b01)
          else value_error($sformatf("AR addr %h len %0d size %0d, expected load %0b %h %0d %0d",
            ar_o.addr, ar_o.len, ar_o.size, cmd.is_load, cmd.addr, cmd.len, cmd.size));
        exp_lsu.push_back(cmd);
        load_pushes++;
      end
      if (aw_valid_o && aw_ready_i) begin
        assert (exp_ax.size() != 0) else abort_run("AW handshake that no instruction asked for");
        assert (load_pushes == load_pops)
          else value_error($sformatf("AW handshake with %0d load commands still queued",
            load_pushes - load_pops));
        cmd = exp_ax.pop_front();
        assert (!cmd.is_load && aw_o.addr == cmd.addr && aw_o.len == cmd.len &&
                aw_o.size == cmd.size && aw_o.burst == 2'b01)
          else value_error($sformatf("AW addr %h len %0d size %0d, expected load %0b %h %0d %0d",
            aw_o.addr, aw_o.len, aw_o.size, cmd.is_load, cmd.addr, cmd.len, cmd.size));
        exp_lsu.push_back(cmd);
      end
      if (ack_o) begin
        assert (exp_ax.size() == 0)
          else value_error($sformatf("Acknowledge with %0d transactions missing", exp_ax.size()));
        assert (ack_info_o.err == exp_ack.err)
          else value_error($sformatf("Ack err %0d, expected %0d", ack_info_o.err, exp_ack.err));
        if (exp_bad) begin
          assert (ack_info_o.err_vl == exp_ack.err_vl &&
                  ack_info_o.err_vaddr == exp_ack.err_vaddr)
            else value_error($sformatf("Ack err_vl %0d err_vaddr %h, expected %0d %h",
              ack_info_o.err_vl, ack_info_o.err_vaddr, exp_ack.err_vl, exp_ack.err_vaddr));
        end
        ack_cnt++;
      end
    end
  end

  initial begin
    void'($urandom(32'hcf635440));
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    ar_ready_i      = 1'b0;
    aw_ready_i      = 1'b0;
    lsu_cmd_ready_i = 1'b0;
    // Unit-stride loads, split at 256 beats and at page ends
    add_row(VLE,  32'h0000_1000, 32'd0,         16'd16,  16'd0, EW32, 1'b0);
    add_row(VLE,  32'h0000_2000, 32'd0,         16'd600, 16'd0, EW64, 1'b0);
    add_row(VLE,  32'h0000_1f80, 32'd0,         16'd64,  16'd0, EW32, 1'b0);
    add_row(VLE,  32'h0000_0ffa, 32'd0,         16'd12,  16'd0, EW16, 1'b0);
    // Strided accesses, one with a negative stride
    add_row(VSSE, 32'h0000_4000, 32'd24,        16'd6,   16'd0, EW64, 1'b0);
    add_row(VSSE, 32'h0000_5002, 32'hffff_fffa, 16'd5,   16'd1, EW16, 1'b0);
    add_row(VLSE, 32'h0000_6000, 32'd12,        16'd4,   16'd0, EW32, 1'b0);
    // Misaligned base, misaligned stride, single element with odd stride
    add_row(VLE,  32'h0000_7002, 32'd0,         16'd4,   16'd0, EW32, 1'b0);
    add_row(VSSE, 32'h0000_8000, 32'd6,         16'd3,   16'd0, EW32, 1'b0);
    add_row(VLSE, 32'h0000_9000, 32'd6,         16'd3,   16'd2, EW32, 1'b0);
    add_row(VSE,  32'h0000_a002, 32'd0,         16'd8,   16'd3, EW64, 1'b0);
    // Load then store while the LSU drains slowly
    add_row(VLSE, 32'h0000_b000, 32'd16,        16'd8,   16'd0, EW64, 1'b1);
    add_row(VSSE, 32'h0000_c000, 32'd8,         16'd4,   16'd0, EW64, 1'b1);
    add_row(VLE,  32'h0000_d000, 32'd0,         16'd4,   16'd4, EW8,  1'b0);
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (req_ready_o && !ack_o && !ar_valid_o && !aw_valid_o && !lsu_cmd_valid_o)
      else value_error("Outputs after reset differ from the idle state");
    for (int unsigned r = 0; r < NumRows; r++) begin
      plan_row(rows[r]);
      lsu_slow = rows[r].slow;
      send_req(rows[r]);
      while (ack_cnt < r + 1) @(negedge clk_i);
    end
    while (exp_lsu.size() != 0) @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vmem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types of vector memory instructions, element widths and error codes
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "addrgen_consts.svh"

package vmem_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`VLEN_WIDTH-1:0] vlen_t;

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {VLE, VSE, VLSE, VSSE} vmem_op_e;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  typedef enum logic [3:0] {
    ERR_NONE           = 4'd0,
    LD_ADDR_MISALIGNED = 4'd4,
    ST_ADDR_MISALIGNED = 4'd6
  } addrgen_err_e;

  typedef struct packed {
    vmem_op_e op;
    addr_t    base;
    addr_t    stride;
    vlen_t    vl;
    vlen_t    vstart;
    vew_e     vew;
  } vmem_req_t;

  typedef struct packed {
    addrgen_err_e err;
    vlen_t        err_vl;
    addr_t        err_vaddr;
  } addrgen_ack_t;

endpackage

`default_nettype wire

// ==== vmem_req_check.sv ====
////////////////////////////////////////////////////////////////////////////
// Front end that checks vector memory instructions and acknowledges them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module vmem_req_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  vmem_pkg::vmem_req_t    req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  output axi_ax_pkg::split_req_t split_req_o,
  output logic                   split_valid_o,
  input  logic                   split_ready_i,
  input  logic                   split_done_i,
  output logic                   ack_o,
  output vmem_pkg::addrgen_ack_t ack_info_o
);
  import vmem_pkg::*;
  import axi_ax_pkg::*;

  typedef enum logic [1:0] {IDLE, CHECK, SPLIT, ACK} state_e;

  state_e       state_q, state_d;
  vmem_req_t    req_q;
  split_req_t   split_q;
  addrgen_ack_t ack_q;
  logic         sent_q;

  addr_t start_addr;
  vlen_t elem_cnt;
  logic  is_burst;
  logic  is_load;
  logic  addr_err;

  function automatic logic misaligned(addr_t addr, vew_e vew);
    addr_t mask;
    mask = (addr_t'(1) << vew) - addr_t'(1);
    return |(addr & mask);
  endfunction

  always_comb begin
    is_burst = req_q.op inside {VLE, VSE};
    is_load  = req_q.op inside {VLE, VLSE};
    elem_cnt = req_q.vl - req_q.vstart;
    // Skip the elements before vstart
    if (is_burst) begin
      start_addr = req_q.base + (addr_t'(req_q.vstart) << req_q.vew);
    end else begin
      start_addr = req_q.base + addr_t'(req_q.vstart) * req_q.stride;
    end
    // The stride only matters when a second element follows
    addr_err = misaligned(start_addr, req_q.vew) ||
               (misaligned(req_q.stride, req_q.vew) && elem_cnt > vlen_t'(1));
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (req_valid_i) state_d = CHECK;
      // Nothing to split for an error or an empty body
      CHECK: state_d = (addr_err || elem_cnt == '0) ? ACK : SPLIT;
      SPLIT: if (split_done_i) state_d = ACK;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == CHECK) begin
        sent_q <= 1'b0;
      end else if (split_valid_o && split_ready_i) begin
        sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
    if (state_q == CHECK) begin
      split_q <= '{addr: start_addr, len: elem_cnt, stride: req_q.stride, vew: req_q.vew,
                   is_load: is_load, is_burst: is_burst};
      ack_q.err       <= !addr_err ? ERR_NONE :
                         is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
      ack_q.err_vl    <= addr_err ? req_q.vstart : '0;
      ack_q.err_vaddr <= addr_err ? start_addr : '0;
    end
  end

  assign req_ready_o   = state_q == IDLE;
  assign split_valid_o = state_q == SPLIT && !sent_q;
  assign split_req_o   = split_q;
  assign ack_o         = state_q == ACK;
  assign ack_info_o    = ack_q;

endmodule

`default_nettype wire
